// ==== include/vnc_config.svh ====
// build constants for the link measurement core, included by the package and the RTL
`ifndef VNC_CONFIG_SVH
`define VNC_CONFIG_SVH

////////////////////////////////////////////////////////////
// pattern pacing and timing
////////////////////////////////////////////////////////////

`define VNC_FRAME_GAP       32'd16  // cycles between pattern pulses
`define VNC_TIMER_WIDTH     16      // timestamp counter width

////////////////////////////////////////////////////////////
// queue depths
////////////////////////////////////////////////////////////

`define VNC_TS_DEPTH        4       // sends waiting for their receive
`define VNC_LAT_DEPTH       8       // deltas waiting for software

// register byte addresses
`define VNC_ADDR_CTRL       8'h00
`define VNC_ADDR_NUM_FRAMES 8'h04
`define VNC_ADDR_STATUS     8'h08
`define VNC_ADDR_LAT_POP    8'h0C
`define VNC_ADDR_SCRATCH    8'h10

`endif

// ==== verilog/vnc_pkg.sv ====
// shared types of the link measurement core, referenced by scoped name from each block
`include "vnc_config.svh"

package vnc_pkg;

    typedef logic [7:0]                  addr_t;       // register byte address
    typedef logic [31:0]                 data_t;       // register data word
    typedef logic [`VNC_TIMER_WIDTH-1:0] lat_time_t;   // timestamp or delta
    typedef logic [15:0]                 frame_cnt_t;  // frame count

    // one request on the strobe bus
    typedef struct packed {
        logic  wr;
        logic  rd;
        addr_t addr;
        data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic       start;       // one-cycle pulse
        frame_cnt_t num_frames;
    } gen_ctl_t;

    typedef struct packed {
        logic      valid;
        lat_time_t delta;
    } lat_entry_t;

    typedef enum logic [1:0] {GEN_IDLE, GEN_RUN, GEN_DONE} gen_state_e;

endpackage

// ==== verilog/vnc_reg_decode.sv ====
// register decode for the strobe bus, drives generator control and the latency queue pop
`timescale 1ns/10ps
`include "vnc_config.svh"

module vnc_reg_decode (
    input  logic                axi_aclk,
    input  logic                axi_aresetn,
    input  vnc_pkg::reg_req_t   i_req,
    input  logic                i_done,
    input  vnc_pkg::lat_entry_t i_head,
    input  logic [3:0]          i_count,
    input  logic                i_overflow,
    output vnc_pkg::data_t      o_rdata,
    output logic                o_rvalid,
    output vnc_pkg::gen_ctl_t   o_gen_ctl,
    output logic                o_pop,
    output logic                o_clear
);

    vnc_pkg::frame_cnt_t num_frames;
    vnc_pkg::data_t      scratch;
    vnc_pkg::addr_t      rd_addr;   // address of the pending read
    logic                rd_pend;   // read sampled on the last edge
    vnc_pkg::data_t      rd_mux;
    logic                ctrl_wr;

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    assign ctrl_wr              = i_req.wr && (i_req.addr == `VNC_ADDR_CTRL);
    assign o_gen_ctl.start      = ctrl_wr && i_req.wdata[0];  // acts on the write edge
    assign o_gen_ctl.num_frames = num_frames;
    assign o_clear              = ctrl_wr && i_req.wdata[1];

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            num_frames <= '0;
            scratch    <= '0;
        end else if (i_req.wr) begin
            case (i_req.addr)
                `VNC_ADDR_NUM_FRAMES: num_frames <= i_req.wdata[15:0];
                `VNC_ADDR_SCRATCH:    scratch    <= i_req.wdata;
                default:              ;  // ctrl and read-only space
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // first stage: remember the read, pop lands with the data capture
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            rd_pend <= 1'b0;
            o_pop   <= 1'b0;
        end else begin
            rd_pend <= i_req.rd;
            o_pop   <= i_req.rd && (i_req.addr == `VNC_ADDR_LAT_POP);
        end
    end

    always_ff @(posedge axi_aclk) begin
        rd_addr <= i_req.addr;
    end

    always_comb begin
        rd_mux = '0;
        case (rd_addr)
            `VNC_ADDR_NUM_FRAMES: rd_mux[15:0] = num_frames;
            `VNC_ADDR_STATUS: begin
                rd_mux[0]    = i_done;
                rd_mux[1]    = i_overflow;
                rd_mux[11:8] = i_count;
            end
            `VNC_ADDR_LAT_POP: begin
                rd_mux[31]                   = i_head.valid;  // zero when queue empty
                rd_mux[`VNC_TIMER_WIDTH-1:0] = i_head.delta;
            end
            `VNC_ADDR_SCRATCH:    rd_mux       = scratch;
            default:              rd_mux       = '0;
        endcase
    end

    // second stage: head is sampled before the pop takes effect
    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            o_rvalid <= 1'b0;
        end else begin
            o_rvalid <= rd_pend;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (rd_pend) begin
            o_rdata <= rd_mux;
        end
    end

endmodule

// ==== verilog/vnc_frame_gen.sv ====
// pattern generator, emits a counted run of pulses at a fixed spacing and then flags done
`timescale 1ns/10ps
`include "vnc_config.svh"

module vnc_frame_gen (
    input  logic              axi_aclk,
    input  logic              axi_aresetn,
    input  vnc_pkg::gen_ctl_t i_gen_ctl,
    output logic              o_pattern_sent,
    output logic              o_done
);

    vnc_pkg::gen_state_e state;
    logic [31:0]         gap_cnt;    // cycles since the last pulse
    vnc_pkg::frame_cnt_t remaining;  // pulses still to send

    assign o_done = (state == vnc_pkg::GEN_DONE);

    ////////////////////////////////////////////////////////////
    // pacing FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            state          <= vnc_pkg::GEN_IDLE;
            gap_cnt        <= '0;
            remaining      <= '0;
            o_pattern_sent <= 1'b0;
        end else begin
            o_pattern_sent <= 1'b0;
            if (i_gen_ctl.start) begin           // restarts an active run too
                gap_cnt <= '0;
                if (i_gen_ctl.num_frames == '0) begin
                    state     <= vnc_pkg::GEN_DONE;
                    remaining <= '0;
                end else begin
                    state          <= vnc_pkg::GEN_RUN;
                    remaining      <= i_gen_ctl.num_frames - 1'b1;
                    o_pattern_sent <= 1'b1;      // first pulse right away
                end
            end else if (state == vnc_pkg::GEN_RUN) begin
                if (remaining == '0) begin
                    state <= vnc_pkg::GEN_DONE;  // cycle after the last pulse
                end else if (gap_cnt == `VNC_FRAME_GAP - 1) begin
                    gap_cnt        <= '0;
                    remaining      <= remaining - 1'b1;
                    o_pattern_sent <= 1'b1;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/vnc_latency_timer.sv ====
// round-trip timer, stamps each sent pattern and matches receives in order to form deltas
`timescale 1ns/10ps
`include "vnc_config.svh"

module vnc_latency_timer (
    input  logic               axi_aclk,
    input  logic               axi_aresetn,
    input  logic               i_pattern_sent,
    input  logic               i_pattern_rcvd,
    output logic               o_delta_valid,
    output vnc_pkg::lat_time_t o_delta
);

    localparam int TS_PTR_W = $clog2(`VNC_TS_DEPTH);
    localparam logic [TS_PTR_W:0] TS_FULL = (TS_PTR_W + 1)'(`VNC_TS_DEPTH);

    vnc_pkg::lat_time_t  now;                          // free-running timestamp
    vnc_pkg::lat_time_t  stamp_mem [`VNC_TS_DEPTH];
    logic [TS_PTR_W-1:0] wr_ptr;
    logic [TS_PTR_W-1:0] rd_ptr;
    logic [TS_PTR_W:0]   ts_count;                     // sends in flight
    logic                push;
    logic                pop;

    // both decisions use the count from before this edge
    assign push = i_pattern_sent && (ts_count != TS_FULL);
    assign pop  = i_pattern_rcvd && (ts_count != '0);  // stray receive is ignored

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            now           <= '0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            ts_count      <= '0;
            o_delta_valid <= 1'b0;
        end else begin
            now           <= now + 1'b1;
            o_delta_valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   ts_count <= ts_count + 1'b1;
                2'b01:   ts_count <= ts_count - 1'b1;
                default: ts_count <= ts_count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // stamp storage and delta
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk) begin
        if (push) begin
            stamp_mem[wr_ptr] <= now;
        end
        if (pop) begin
            o_delta <= now - stamp_mem[rd_ptr];  // wraps modulo timer width
        end
    end

endmodule

// ==== verilog/vnc_latency_fifo.sv ====
// result queue for measured deltas, popped by software, with a sticky overflow flag
`timescale 1ns/10ps
`include "vnc_config.svh"

module vnc_latency_fifo (
    input  logic                axi_aclk,
    input  logic                axi_aresetn,
    input  logic                i_delta_valid,
    input  vnc_pkg::lat_time_t  i_delta,
    input  logic                i_pop,
    input  logic                i_clear,
    output vnc_pkg::lat_entry_t o_head,
    output logic [3:0]          o_count,
    output logic                o_overflow
);

    localparam int LAT_PTR_W = $clog2(`VNC_LAT_DEPTH);
    localparam logic [3:0] LAT_FULL = 4'(`VNC_LAT_DEPTH);

    vnc_pkg::lat_time_t   mem [`VNC_LAT_DEPTH];
    logic [LAT_PTR_W-1:0] wr_ptr;
    logic [LAT_PTR_W-1:0] rd_ptr;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full         = (o_count == LAT_FULL);
    assign push         = i_delta_valid && !full;  // no back-pressure to the link
    assign pop          = i_pop && (o_count != '0);
    assign o_head.valid = (o_count != '0);
    assign o_head.delta = o_head.valid ? mem[rd_ptr] : '0;

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn || i_clear) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            o_count    <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_delta_valid && full) begin
                o_overflow <= 1'b1;                // delta lost, sticky
            end
            o_count <= o_count + {3'b000, push} - {3'b000, pop};
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= i_delta;
        end
    end

endmodule

// ==== verilog/vnc_core.sv ====
// top level of the link measurement core, ties decode, generator, timer and queue together
`timescale 1ns/10ps

module vnc_core (
    input  logic              axi_aclk,
    input  logic              axi_aresetn,
    input  vnc_pkg::reg_req_t i_req,
    input  logic              i_pattern_rcvd,
    output vnc_pkg::data_t    o_rdata,
    output logic              o_rvalid,
    output logic              o_pattern_sent
);

    vnc_pkg::gen_ctl_t   gen_ctl;
    vnc_pkg::lat_entry_t lat_head;
    vnc_pkg::lat_time_t  delta;
    logic                delta_valid;
    logic                gen_done;
    logic                lat_pop;
    logic                lat_clear;
    logic                lat_overflow;
    logic [3:0]          lat_count;

    ////////////////////////////////////////////////////////////
    // register decode
    ////////////////////////////////////////////////////////////

    vnc_reg_decode u_reg_decode (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .i_req       (i_req),
        .i_done      (gen_done),
        .i_head      (lat_head),
        .i_count     (lat_count),
        .i_overflow  (lat_overflow),
        .o_rdata     (o_rdata),
        .o_rvalid    (o_rvalid),
        .o_gen_ctl   (gen_ctl),
        .o_pop       (lat_pop),
        .o_clear     (lat_clear)
    );

    ////////////////////////////////////////////////////////////
    // pattern pacing and latency measurement
    ////////////////////////////////////////////////////////////

    vnc_frame_gen u_frame_gen (
        .axi_aclk       (axi_aclk),
        .axi_aresetn    (axi_aresetn),
        .i_gen_ctl      (gen_ctl),
        .o_pattern_sent (o_pattern_sent),  // also feeds the timer
        .o_done         (gen_done)
    );

    vnc_latency_timer u_latency_timer (
        .axi_aclk       (axi_aclk),
        .axi_aresetn    (axi_aresetn),
        .i_pattern_sent (o_pattern_sent),
        .i_pattern_rcvd (i_pattern_rcvd),
        .o_delta_valid  (delta_valid),
        .o_delta        (delta)
    );

    vnc_latency_fifo u_latency_fifo (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .i_delta_valid (delta_valid),
        .i_delta       (delta),
        .i_pop         (lat_pop),
        .i_clear       (lat_clear),
        .o_head        (lat_head),
        .o_count       (lat_count),
        .o_overflow    (lat_overflow)
    );

endmodule

// ==== verification/vnc_core_chk.sv ====
// protocol assertions for the link measurement core, attached to every vnc_core by bind
`timescale 1ns/10ps
`include "vnc_config.svh"

module vnc_core_chk (
    input logic              axi_aclk,
    input logic              axi_aresetn,
    input vnc_pkg::reg_req_t i_req,
    input logic              i_rvalid,
    input logic              i_pattern_sent
);

    int unsigned fail_count = 0;  // fired assertions
    logic [1:0]  rd_hist;         // read strobes of the last two edges

    always_ff @(posedge axi_aclk) begin
        if (!axi_aresetn) begin
            rd_hist <= 2'b00;
        end else begin
            rd_hist <= {rd_hist[0], i_req.rd};
        end
    end

    ////////////////////////////////////////////////////////////
    // bus and pacing rules
    ////////////////////////////////////////////////////////////

    rvalid_after_read: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn) i_rvalid == rd_hist[1]
    ) else begin
        $error("o_rvalid does not match the read strobe two edges earlier");
        fail_count++;
    end

    pulse_spacing: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        i_pattern_sent |=> (!i_pattern_sent) [*(`VNC_FRAME_GAP - 1)]
    ) else begin
        $error("two pattern pulses closer than the frame gap");
        fail_count++;
    end

    quiet_after_reset: assert property (
        @(posedge axi_aclk) !axi_aresetn |=> (!i_pattern_sent && !i_rvalid)
    ) else begin
        $error("outputs active in the cycle after reset");
        fail_count++;
    end

endmodule

bind vnc_core vnc_core_chk u_chk (
    .axi_aclk       (axi_aclk),
    .axi_aresetn    (axi_aresetn),
    .i_req          (i_req),
    .i_rvalid       (o_rvalid),
    .i_pattern_sent (o_pattern_sent)
);

// ==== verification/vnc_core_tb.sv ====
// testbench for the link measurement core that drives the strobe bus and loops patterns back
`timescale 1ns/10ps
`include "vnc_config.svh"

module vnc_core_tb;

    localparam int unsigned SEED     = 32'h7930;
    localparam int unsigned WAIT_MAX = 100;           // cycles allowed per wait loop
    localparam int unsigned DLY_MIN  = 3;
    localparam int unsigned DLY_MAX  = 40;
    localparam int unsigned GAP      = `VNC_FRAME_GAP;

    logic              axi_aclk;
    logic              axi_aresetn;
    vnc_pkg::reg_req_t i_req;
    logic              i_pattern_rcvd;
    vnc_pkg::data_t    o_rdata;
    logic              o_rvalid;
    logic              o_pattern_sent;

    int unsigned cycle    = 0;  // rising edges so far
    int unsigned last_rcv = 0;  // cycle of the latest scheduled receive
    int unsigned sent_q[$];     // cycle of each observed pulse
    int unsigned rcv_q[$];      // pending receive cycles
    int unsigned dly_q[$];      // loopback delays in send order

    vnc_core DUT (
        .axi_aclk       (axi_aclk),
        .axi_aresetn    (axi_aresetn),
        .i_req          (i_req),
        .i_pattern_rcvd (i_pattern_rcvd),
        .o_rdata        (o_rdata),
        .o_rvalid       (o_rvalid),
        .o_pattern_sent (o_pattern_sent)
    );

    initial begin
        axi_aclk = 1'b0;
        forever #10 axi_aclk = ~axi_aclk;
    end

    always @(posedge axi_aclk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // link loopback that keeps receives in send order
    ////////////////////////////////////////////////////////////

    always @(negedge axi_aclk) begin
        int unsigned dly;
        if (o_pattern_sent === 1'b1) begin
            dly = DLY_MIN + ($urandom % (DLY_MAX - DLY_MIN + 1));
            if (cycle + dly <= last_rcv) begin
                dly = last_rcv - cycle + 1;  // no overtaking on the link
            end
            last_rcv = cycle + dly;
            sent_q.push_back(cycle);
            rcv_q.push_back(last_rcv);
            dly_q.push_back(dly);
        end
        if (rcv_q.size() != 0 && rcv_q[0] == cycle) begin
            i_pattern_rcvd <= 1'b1;
            void'(rcv_q.pop_front());
        end else begin
            i_pattern_rcvd <= 1'b0;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // any fired protocol assertion ends the run at once
    always @(negedge axi_aclk) begin
        if (DUT.u_chk.fail_count != 0) begin
            stop_with_failure("a protocol assertion in the bound checker fired");
        end
    end

    task automatic compare_value(input string name, input vnc_pkg::data_t exp_val,
                                 input vnc_pkg::data_t act_val);
        assert (act_val === exp_val) else begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s expected %08h actual %08h",
                                        $time, name, exp_val, act_val));
        end
    endtask

    task automatic write_reg(input vnc_pkg::addr_t addr, input vnc_pkg::data_t data);
        @(negedge axi_aclk);
        i_req.wr    = 1'b1;
        i_req.addr  = addr;
        i_req.wdata = data;
        @(negedge axi_aclk);
        i_req.wr = 1'b0;
    endtask

    task automatic check_read(input string name, input vnc_pkg::addr_t addr,
                              input vnc_pkg::data_t exp_val);
        int unsigned waited;
        @(negedge axi_aclk);
        i_req.rd   = 1'b1;
        i_req.addr = addr;
        @(negedge axi_aclk);
        i_req.rd = 1'b0;
        waited   = 0;
        while (o_rvalid !== 1'b1 && waited < WAIT_MAX) begin
            @(negedge axi_aclk);
            waited++;
        end
        if (o_rvalid !== 1'b1) begin
            stop_with_failure($sformatf("read of %s never returned o_rvalid", name));
        end else begin
            compare_value(name, exp_val, o_rdata);
        end
    endtask

    // start a run of n frames, check the pulse train, then let the link drain
    task automatic run_and_check_train(input int unsigned n);
        int unsigned start_cyc;
        int unsigned waited;
        int unsigned i;
        sent_q.delete();
        dly_q.delete();
        write_reg(`VNC_ADDR_NUM_FRAMES, n);
        write_reg(`VNC_ADDR_CTRL, 32'h1);
        start_cyc = cycle;  // first pulse falls in this cycle
        waited    = 0;
        while (sent_q.size() < n && waited < n * GAP + WAIT_MAX) begin
            @(negedge axi_aclk);
            waited++;
        end
        if (sent_q.size() < n) begin
            stop_with_failure("pattern pulses stopped before the requested count");
        end
        compare_value("first pulse cycle", start_cyc, sent_q[0]);
        for (i = 1; i < n; i++) begin
            compare_value("pulse spacing", GAP, sent_q[i] - sent_q[i-1]);
        end
        repeat (3 * GAP) @(negedge axi_aclk);
        compare_value("pulse count", n, sent_q.size());
        waited = 0;
        while (rcv_q.size() != 0 && waited < WAIT_MAX) begin
            @(negedge axi_aclk);
            waited++;
        end
        if (rcv_q.size() != 0) begin
            stop_with_failure("loopback receives were still pending after the run");
        end
        repeat (3) @(negedge axi_aclk);  // delta lands two edges after the receive
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        vnc_pkg::data_t wval;
        int unsigned    seed;
        int unsigned    n;
        int unsigned    i;
        seed           = $urandom(SEED);
        i_req          = '0;
        i_pattern_rcvd = 1'b0;
        axi_aresetn    = 1'b0;
        repeat (2) @(negedge axi_aclk);
        axi_aresetn = 1'b1;

        check_read("STATUS", `VNC_ADDR_STATUS, 32'h0);
        check_read("NUM_FRAMES", `VNC_ADDR_NUM_FRAMES, 32'h0);
        check_read("SCRATCH", `VNC_ADDR_SCRATCH, 32'h0);
        check_read("LAT_POP", `VNC_ADDR_LAT_POP, 32'h0);

        repeat (4) begin
            wval = $urandom;
            write_reg(`VNC_ADDR_SCRATCH, wval);
            check_read("SCRATCH", `VNC_ADDR_SCRATCH, wval);
            wval = $urandom;
            write_reg(`VNC_ADDR_NUM_FRAMES, wval);
            check_read("NUM_FRAMES", `VNC_ADDR_NUM_FRAMES, wval & 32'h0000_ffff);
        end

        n = 1 + ($urandom % 6);
        run_and_check_train(n);
        for (i = 0; i < n; i++) begin
            check_read("STATUS", `VNC_ADDR_STATUS, ((n - i) << 8) | 32'h1);
            check_read("LAT_POP", `VNC_ADDR_LAT_POP, 32'h8000_0000 | dly_q[i]);
        end
        check_read("LAT_POP", `VNC_ADDR_LAT_POP, 32'h0);
        check_read("STATUS", `VNC_ADDR_STATUS, 32'h1);

        // ten deltas into an eight deep queue
        run_and_check_train(10);
        check_read("STATUS", `VNC_ADDR_STATUS, 32'h0000_0803);
        for (i = 0; i < 8; i++) begin
            check_read("LAT_POP", `VNC_ADDR_LAT_POP, 32'h8000_0000 | dly_q[i]);
        end
        write_reg(`VNC_ADDR_CTRL, 32'h2);
        check_read("STATUS", `VNC_ADDR_STATUS, 32'h1);

        if (DUT.u_chk.fail_count != 0) begin
            stop_with_failure("a protocol assertion in the bound checker fired");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/vnc_pkg.sv
verilog/vnc_reg_decode.sv
verilog/vnc_frame_gen.sv
verilog/vnc_latency_timer.sv
verilog/vnc_latency_fifo.sv
verilog/vnc_core.sv
verification/vnc_core_chk.sv
verification/vnc_core_tb.sv
